// File: Makefile
TOP := ibuf_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Simulation failed" sim.log; then exit 1; fi; exit $$status

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module ibuf_top

clean:
	rm -rf obj_dir sim.log

// File: bench/ibuf_model.svh
`ifndef IBUF_MODEL_SVH
`define IBUF_MODEL_SVH

// shadow of the slot lines, valid bits and bip
line_t [NUM_SLOTS-1:0] m_line;
slot_mask_t            m_valid;
bip_t                  m_bip;

task automatic model_reset();
    m_valid = '0;
    m_bip   = '0;
endtask

// even side writes slot 0 or 2, odd side 1 or 3, empty slots only
function automatic slot_mask_t model_load(input fetch_t f, input logic flush,
                                          input slot_mask_t valid);
    slot_mask_t hit;
    hit = '0;
    if (!f.miss_even && !f.stall_even && !f.fip_e[0]) begin
        hit[f.fip_e] = 1'b1;
    end
    if (!f.miss_odd && !f.stall_odd && f.fip_o[0]) begin
        hit[f.fip_o] = 1'b1;
    end
    // nothing loads in a flush cycle
    if (flush) begin
        hit = '0;
    end
    return hit & ~valid;
endfunction

// slot under bip valid, plus the next one when bip is unaligned
function automatic logic model_window_valid(input slot_mask_t valid, input bip_t b);
    slot_idx_t s;
    s = b[5:4];
    if (!valid[s]) begin
        return 1'b0;
    end
    if (b[3:0] == 4'd0) begin
        return 1'b1;
    end
    return valid[s + 2'd1];
endfunction

// byte k is ring byte b+k mod 64
function automatic line_t model_window(input line_t [NUM_SLOTS-1:0] lines, input bip_t b);
    line_t w;
    bip_t  idx;
    for (int k = 0; k < LINE_BYTES; k++) begin
        idx = b + bip_t'(k);
        w[8*k +: 8] = lines[idx[5:4]][8*idx[3:0] +: 8];
    end
    return w;
endfunction

// old slot freed when the new offset does not exceed the old one
function automatic slot_mask_t model_free(input bip_t b, input logic accept, input len_t len);
    slot_mask_t f;
    bip_t       nb;
    f  = '0;
    nb = b + bip_t'(len);
    if (accept && (nb[3:0] <= b[3:0])) begin
        f[b[5:4]] = 1'b1;
    end
    return f;
endfunction

// advance the shadow state by one clock
task automatic model_step(input fetch_t f, input logic flush, input bip_t redirect,
                          input logic cons, input len_t len);
    slot_mask_t load;
    slot_mask_t freed;
    logic       accept;
    load   = model_load(f, flush, m_valid);
    accept = cons && !flush && model_window_valid(m_valid, m_bip);
    freed  = model_free(m_bip, accept, len);
    for (int s = 0; s < NUM_SLOTS; s++) begin
        if (load[s]) begin
            m_line[s] = (s % 2 == 0) ? f.even_line : f.odd_line;
        end
    end
    if (flush) begin
        m_valid = '0;
        m_bip   = redirect;
    end else begin
        m_valid = (m_valid & ~freed) | load;
        if (accept) begin
            m_bip = m_bip + bip_t'(len);
        end
    end
endtask

`endif

// File: bench/ibuf_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_tb
    import ibuf_pkg::*;
();

    logic        clk;
    logic        arst_n;
    fetch_t      fetch;
    logic        branch_taken;
    logic        resteer;
    logic        init;
    bip_t        redirect_bip;
    logic        consume;
    len_t        consume_len;
    line_t       window;
    logic        window_valid;
    bip_t        bip;
    slot_mask_t  slot_valid;
    logic        even_loaded;
    logic        odd_loaded;

    // run bookkeeping
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;
    logic [31:0] lcg_state;

    `include "ibuf_model.svh"

    ibuf_top u_dut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .fetch_i        (fetch),
        .branch_taken_i (branch_taken),
        .resteer_i      (resteer),
        .init_i         (init),
        .redirect_bip_i (redirect_bip),
        .consume_i      (consume),
        .consume_len_i  (consume_len),
        .window_o       (window),
        .window_valid_o (window_valid),
        .bip_o          (bip),
        .slot_valid_o   (slot_valid),
        .even_loaded_o  (even_loaded),
        .odd_loaded_o   (odd_loaded)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // one lcg step whose upper half carries the useful bits
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = lcg_next();
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got %0h expected %0h at %0t",
                     name, got, exp, $time);
            errors++;
            test_errors++;
        end
    endtask

    // drive point is 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic settle();
        @(negedge clk);
    endtask

    // both sides missing and no pulses
    task automatic idle_inputs();
        fetch.fip_e      = 2'd0;
        fetch.fip_o      = 2'd1;
        fetch.miss_even  = 1'b1;
        fetch.miss_odd   = 1'b1;
        fetch.stall_even = 1'b0;
        fetch.stall_odd  = 1'b0;
        branch_taken     = 1'b0;
        resteer          = 1'b0;
        init             = 1'b0;
        consume          = 1'b0;
        consume_len      = 5'd1;
    endtask

    task automatic drive_fetch(input line_t el, input line_t ol, input slot_idx_t fe,
                               input slot_idx_t fo, input logic me, input logic mo,
                               input logic se, input logic so);
        fetch.even_line  = el;
        fetch.odd_line   = ol;
        fetch.fip_e      = fe;
        fetch.fip_o      = fo;
        fetch.miss_even  = me;
        fetch.miss_odd   = mo;
        fetch.stall_even = se;
        fetch.stall_odd  = so;
    endtask

    task automatic check_loaded(input logic exp_even, input logic exp_odd);
        check_value("even_loaded_o", 128'(even_loaded), 128'(exp_even));
        check_value("odd_loaded_o", 128'(odd_loaded), 128'(exp_odd));
    endtask

    task automatic wait_window_valid(input int max_cycles);
        for (int n = 0; n < max_cycles && !window_valid; n++) begin
            next_cycle();
        end
        if (!window_valid) begin
            $display("ERROR: window did not become valid within %0d cycles", max_cycles);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // short delay lets the compare process finish its checks first
    task automatic end_test();
        #1;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", tests_run, test_name, test_errors);
        end
    endtask

    // model is checked against the DUT and then stepped, every cycle
    always @(negedge clk) begin : compare
        logic       flush;
        slot_mask_t exp_load;
        flush = branch_taken | resteer | init;
        if (!arst_n) begin
            model_reset();
        end else begin
            exp_load = model_load(fetch, flush, m_valid);
            check_value("slot_valid_o", 128'(slot_valid), 128'(m_valid));
            check_value("bip_o", 128'(bip), 128'(m_bip));
            check_value("window_valid_o", 128'(window_valid),
                        128'(model_window_valid(m_valid, m_bip)));
            check_value("even_loaded_o", 128'(even_loaded), 128'(|(exp_load & 4'b0101)));
            check_value("odd_loaded_o", 128'(odd_loaded), 128'(|(exp_load & 4'b1010)));
            if (model_window_valid(m_valid, m_bip)) begin
                check_value("window_o", window, model_window(m_line, m_bip));
            end
            model_step(fetch, flush, redirect_bip, consume, consume_len);
        end
    end

    initial begin : main
        line_t       l0;
        line_t       l3;
        bip_t        old_bip;
        bip_t        exp_bip;
        slot_mask_t  old_valid;
        slot_idx_t   old_slot;
        len_t        len;
        logic        crossed;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lcg_state    = 32'd25926;
        arst_n       = 1'b0;
        redirect_bip = '0;
        fetch        = '0;
        idle_inputs();
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        start_test("reset and load");
        settle();
        check_value("slot_valid_o", 128'(slot_valid), 128'h0);
        check_value("window_valid_o", 128'(window_valid), 128'h0);
        check_value("bip_o", 128'(bip), 128'h0);
        check_loaded(1'b0, 1'b0);
        next_cycle();
        l0 = random_line();
        drive_fetch(l0, random_line(), 2'd0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0);
        settle();
        check_loaded(1'b1, 1'b1);
        next_cycle();
        idle_inputs();
        settle();
        check_value("slot_valid_o", 128'(slot_valid), 128'h3);
        check_value("window_valid_o", 128'(window_valid), 128'h1);
        check_value("window_o", window, l0);
        end_test();

        start_test("miss and stall gating");
        // even miss with odd stall blocks both sides
        next_cycle();
        drive_fetch(random_line(), random_line(), 2'd2, 2'd3, 1'b1, 1'b0, 1'b0, 1'b1);
        settle();
        check_loaded(1'b0, 1'b0);
        next_cycle();
        drive_fetch(random_line(), random_line(), 2'd2, 2'd3, 1'b0, 1'b0, 1'b1, 1'b0);
        settle();
        check_loaded(1'b0, 1'b1);
        next_cycle();
        drive_fetch(random_line(), random_line(), 2'd2, 2'd3, 1'b0, 1'b1, 1'b0, 1'b0);
        settle();
        check_value("slot_valid_o", 128'(slot_valid), 128'hb);
        check_loaded(1'b1, 1'b0);
        // a fetch aimed at live slots must not overwrite them
        next_cycle();
        drive_fetch(random_line(), random_line(), 2'd0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0);
        settle();
        check_loaded(1'b0, 1'b0);
        next_cycle();
        idle_inputs();
        settle();
        check_value("slot_valid_o", 128'(slot_valid), 128'hf);
        check_value("window_o", window, l0);
        end_test();

        start_test("window across slots");
        next_cycle();
        init         = 1'b1;
        redirect_bip = 6'h3a;
        settle();
        next_cycle();
        idle_inputs();
        l3 = random_line();
        drive_fetch(random_line(), l3, 2'd2, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0);
        settle();
        check_value("bip_o", 128'(bip), 128'h3a);
        check_value("window_valid_o", 128'(window_valid), 128'h0);
        next_cycle();
        l0 = random_line();
        drive_fetch(l0, random_line(), 2'd0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0);
        settle();
        // slot 3 valid but slot 0 still empty
        check_value("slot_valid_o", 128'(slot_valid), 128'hc);
        check_value("window_valid_o", 128'(window_valid), 128'h0);
        next_cycle();
        idle_inputs();
        settle();
        check_value("window_valid_o", 128'(window_valid), 128'h1);
        check_value("window_o", window, {l0[79:0], l3[127:80]});
        end_test();

        start_test("consume and free");
        for (int i = 0; i < 24; i++) begin
            next_cycle();
            idle_inputs();
            wait_window_valid(16);
            old_bip   = bip;
            old_valid = slot_valid;
            old_slot  = bip[5:4];
            r         = lcg_next();
            len       = {1'b0, r[19:16]} + 5'd1;
            exp_bip   = old_bip + {1'b0, len};
            crossed   = exp_bip[3:0] <= old_bip[3:0];
            consume     = 1'b1;
            consume_len = len;
            next_cycle();
            idle_inputs();
            settle();
            check_value("bip_o", 128'(bip), 128'(exp_bip));
            if (crossed) begin
                check_value("slot_valid_o", 128'(slot_valid),
                            128'(old_valid & ~(slot_mask_t'(1) << old_slot)));
                // refill the freed slot while its partner stays untouched
                next_cycle();
                drive_fetch(random_line(), random_line(), {old_slot[1], 1'b0},
                            {old_slot[1], 1'b1}, 1'b0, 1'b0, 1'b0, 1'b0);
                settle();
                check_loaded(!old_slot[0], old_slot[0]);
            end else begin
                check_value("slot_valid_o", 128'(slot_valid), 128'(old_valid));
            end
        end
        end_test();

        start_test("flush");
        // empty the ring first so the fetch in the first flush cycle has free slots
        next_cycle();
        idle_inputs();
        init = 1'b1;
        for (int kind = 0; kind < 3; kind++) begin
            next_cycle();
            idle_inputs();
            r            = lcg_next();
            redirect_bip = r[21:16];
            branch_taken = (kind == 0);
            resteer      = (kind == 1);
            init         = (kind == 2);
            drive_fetch(random_line(), random_line(), 2'd0, 2'd1, 1'b0, 1'b0, 1'b0, 1'b0);
            settle();
            check_loaded(1'b0, 1'b0);
            next_cycle();
            idle_inputs();
            drive_fetch(random_line(), random_line(), 2'd2, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0);
            settle();
            check_value("slot_valid_o", 128'(slot_valid), 128'h0);
            check_value("bip_o", 128'(bip), 128'(r[21:16]));
            check_loaded(1'b1, 1'b1);
        end
        end_test();

        start_test("random run");
        for (int c = 0; c < 2000; c++) begin
            next_cycle();
            r  = lcg_next();
            r2 = lcg_next();
            r3 = lcg_next();
            drive_fetch(random_line(), random_line(), {r[16], 1'b0}, {r[17], 1'b1},
                        r[20:18] == 3'd0, r[23:21] == 3'd0,
                        r[26:24] == 3'd0, r[29:27] == 3'd0);
            // flush about once in 64 cycles
            branch_taken = (r2[21:16] == 6'd0) && (r2[23:22] == 2'd0);
            resteer      = (r2[21:16] == 6'd0) && (r2[23:22] == 2'd1);
            init         = (r2[21:16] == 6'd0) && r2[23];
            redirect_bip = r2[29:24];
            consume      = r2[30] && model_window_valid(m_valid, m_bip);
            consume_len  = {1'b0, r3[19:16]} + 5'd1;
        end
        next_cycle();
        idle_inputs();
        settle();
        end_test();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/ibuf_byte_window.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_byte_window
    import ibuf_pkg::*;
(
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire                         flush_i,
    input  wire bip_t                   redirect_bip_i,
    input  wire                         consume_i,
    input  wire len_t                   consume_len_i,
    input  wire line_t [NUM_SLOTS-1:0]  slot_line_i,
    input  wire slot_mask_t             slot_valid_i,
    output line_t                       window_o,
    output logic                        window_valid_o,
    output bip_t                        bip_o,
    output slot_mask_t                  free_o
);

    // buffer instruction pointer
    bip_t      bip_q;

    // pointer after this cycle's consume
    bip_t      bip_adv;

    // slot under bip and the one after it in the ring
    slot_idx_t cur_slot;
    slot_idx_t nxt_slot;

    // byte offsets before and after the consume
    off_t      cur_off;
    off_t      adv_off;

    // ring with slot 0 repeated on top so the window can wrap
    logic [LINE_W*(NUM_SLOTS+1)-1:0] ring;

    // decoder consume taken this cycle
    logic      accept;

    // consume leaves the current slot behind
    logic      crossed;

    assign cur_slot = bip_q[BIP_W-1:OFF_W];
    assign cur_off  = bip_q[OFF_W-1:0];
    assign nxt_slot = cur_slot + slot_idx_t'(1);

    // byte k of the window is ring byte bip+k mod 64
    assign ring     = {slot_line_i[0], slot_line_i};
    assign window_o = ring[{bip_q, 3'b000} +: LINE_W];

    // an aligned bip reads one slot, otherwise the window spans two
    assign window_valid_o = slot_valid_i[cur_slot] &&
                            ((cur_off == '0) || slot_valid_i[nxt_slot]);

    // flush overrides any consume in the same cycle
    assign accept = consume_i && window_valid_o && !flush_i;

    // wraps naturally at 64
    assign bip_adv = bip_q + bip_t'(consume_len_i);
    assign adv_off = bip_adv[OFF_W-1:0];

    // len is at most 16, so a non-increasing offset means a boundary was passed
    assign crossed = (adv_off <= cur_off);

    // free the slot bip is leaving
    always_comb begin
        free_o = '0;
        if (accept && crossed) begin
            free_o[cur_slot] = 1'b1;
        end
    end

    // redirect wins over advance
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bip_q <= '0;
        end else if (flush_i) begin
            bip_q <= redirect_bip_i;
        end else if (accept) begin
            bip_q <= bip_adv;
        end
    end

    assign bip_o = bip_q;

    // decoder may only consume from a complete window
    a_consume_needs_window: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        consume_i |-> window_valid_o
    ) else $error("consume while window invalid, bip %0d", bip_q);

    // consume length must fit one window
    a_consume_len_legal: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        consume_i |-> (consume_len_i inside {[1:LINE_BYTES]})
    ) else $error("illegal consume length %0d", consume_len_i);

endmodule

`default_nettype wire

// File: source/ibuf_fill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_fill_ctrl
    import ibuf_pkg::*;
(
    input  wire fetch_t                     fetch_i,
    input  wire                             branch_taken_i,
    input  wire                             resteer_i,
    input  wire                             init_i,
    input  wire slot_mask_t                 slot_valid_i,
    output slot_cmd_t [NUM_SLOTS-1:0]       slot_cmd_o,
    output logic                            flush_o,
    output logic                            even_loaded_o,
    output logic                            odd_loaded_o
);

    // any control-flow change empties the ring
    logic       flush;

    // one-hot slot targets of each fetch line
    slot_mask_t even_hit;
    slot_mask_t odd_hit;

    // side is allowed to write this cycle
    logic       even_ok;
    logic       odd_ok;

    // final per-slot load strobes
    slot_mask_t load;

    assign flush = branch_taken_i | resteer_i | init_i;

    // decode fip, dropping any match onto a slot of the wrong parity
    assign even_hit = (NUM_SLOTS'(1) << fetch_i.fip_e) & EVEN_SLOT_MASK;
    assign odd_hit  = (NUM_SLOTS'(1) << fetch_i.fip_o) & ~EVEN_SLOT_MASK;

    // a miss means no data, a stall means the side is held
    assign even_ok = !fetch_i.miss_even && !fetch_i.stall_even;
    assign odd_ok  = !fetch_i.miss_odd && !fetch_i.stall_odd;

    // only empty slots take a line, and never during a flush
    assign load = ((even_hit & {NUM_SLOTS{even_ok}}) |
                   (odd_hit & {NUM_SLOTS{odd_ok}})) &
                  ~slot_valid_i &
                  {NUM_SLOTS{!flush}};

    // fan out the command to each slot
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            slot_cmd_o[s].load  = load[s];
            slot_cmd_o[s].flush = flush;
        end
    end

    assign flush_o = flush;

    // loaded flags go back to fetch in the same cycle
    assign even_loaded_o = |(load & EVEN_SLOT_MASK);
    assign odd_loaded_o  = |(load & ~EVEN_SLOT_MASK);

    // icache must aim the even line at slot 0 or 2, the odd line at 1 or 3
    always_comb begin
        assert (fetch_i.fip_e[0] !== 1'b1)
            else $error("fip_e points at odd slot %0d", fetch_i.fip_e);
        assert (fetch_i.fip_o[0] !== 1'b0)
            else $error("fip_o points at even slot %0d", fetch_i.fip_o);
    end

endmodule

`default_nettype wire

// File: source/ibuf_line_slot.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_line_slot
    import ibuf_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire slot_cmd_t cmd_i,
    input  wire            free_i,
    input  wire line_t     line_i,
    output line_t          line_o,
    output logic           valid_o
);

    // held cache line
    line_t line_q;

    // slot holds a usable line
    logic  valid_q;

    // flush and free both empty the slot, and win over load
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (cmd_i.flush || free_i) begin
            valid_q <= 1'b0;
        end else if (cmd_i.load) begin
            valid_q <= 1'b1;
        end
    end

    // line data follows the load strobe
    always_ff @(posedge clk) begin
        if (cmd_i.load) begin
            line_q <= line_i;
        end
    end

    assign line_o  = line_q;
    assign valid_o = valid_q;

    // fill side must never overwrite a live line
    a_no_load_when_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cmd_i.load |-> !valid_q
    ) else $error("load into a valid slot");

    // window side only frees a slot it is reading, so never one being filled
    a_no_load_with_free: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(cmd_i.load && free_i)
    ) else $error("load and free in the same cycle");

endmodule

`default_nettype wire

// File: source/ibuf_pkg.sv
`default_nettype none

package ibuf_pkg;

    // ring geometry
    localparam int NUM_SLOTS  = 4;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = LINE_BYTES * 8;

    // bip splits into slot index (upper) and byte offset (lower)
    localparam int SLOT_IDX_W = 2;
    localparam int OFF_W      = 4;
    localparam int BIP_W      = SLOT_IDX_W + OFF_W;

    // consume length covers 1..16, so one bit wider than the offset
    localparam int LEN_W      = OFF_W + 1;

    // slots 0 and 2 hold even lines, 1 and 3 hold odd lines
    localparam logic [NUM_SLOTS-1:0] EVEN_SLOT_MASK = 4'b0101;

    // one 16-byte cache line
    typedef logic [LINE_W-1:0]     line_t;

    // buffer instruction pointer into the 64-byte ring
    typedef logic [BIP_W-1:0]      bip_t;

    // slot number within the ring
    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

    // byte offset within one slot
    typedef logic [OFF_W-1:0]      off_t;

    // decoder consume length
    typedef logic [LEN_W-1:0]      len_t;

    // one bit per slot
    typedef logic [NUM_SLOTS-1:0]  slot_mask_t;

    // everything the icache hands over in one fetch cycle
    typedef struct packed {
        line_t     even_line;
        line_t     odd_line;
        slot_idx_t fip_e;
        slot_idx_t fip_o;
        logic      miss_even;
        logic      miss_odd;
        // write hold per side
        logic      stall_even;
        logic      stall_odd;
    } fetch_t;

    // per-slot command from the fill controller
    typedef struct packed {
        logic load;
        logic flush;
    } slot_cmd_t;

endpackage

`default_nettype wire

// File: source/ibuf_top.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_top
    import ibuf_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n_i,
    input  wire fetch_t     fetch_i,
    input  wire             branch_taken_i,
    input  wire             resteer_i,
    input  wire             init_i,
    input  wire bip_t       redirect_bip_i,
    input  wire             consume_i,
    input  wire len_t       consume_len_i,
    output wire line_t      window_o,
    output wire             window_valid_o,
    output wire bip_t       bip_o,
    output wire slot_mask_t slot_valid_o,
    output wire             even_loaded_o,
    output wire             odd_loaded_o
);

    // per-slot load and flush
    wire slot_cmd_t [NUM_SLOTS-1:0] slot_cmd;

    // control-flow flush to the window unit
    wire                            flush;

    // line contents of each slot
    wire line_t [NUM_SLOTS-1:0]     slot_line;

    // free pulses from the window unit
    wire slot_mask_t                slot_free;

    ibuf_fill_ctrl u_fill_ctrl (
        .fetch_i        (fetch_i),
        .branch_taken_i (branch_taken_i),
        .resteer_i      (resteer_i),
        .init_i         (init_i),
        .slot_valid_i   (slot_valid_o),
        .slot_cmd_o     (slot_cmd),
        .flush_o        (flush),
        .even_loaded_o  (even_loaded_o),
        .odd_loaded_o   (odd_loaded_o)
    );

    // even slots take the even line, odd slots the odd line
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        ibuf_line_slot u_slot (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .cmd_i    (slot_cmd[s]),
            .free_i   (slot_free[s]),
            .line_i   ((s % 2 == 0) ? fetch_i.even_line : fetch_i.odd_line),
            .line_o   (slot_line[s]),
            .valid_o  (slot_valid_o[s])
        );
    end

    ibuf_byte_window u_byte_window (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush),
        .redirect_bip_i (redirect_bip_i),
        .consume_i      (consume_i),
        .consume_len_i  (consume_len_i),
        .slot_line_i    (slot_line),
        .slot_valid_i   (slot_valid_o),
        .window_o       (window_o),
        .window_valid_o (window_valid_o),
        .bip_o          (bip_o),
        .free_o         (slot_free)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
source/ibuf_pkg.sv
source/ibuf_fill_ctrl.sv
source/ibuf_line_slot.sv
source/ibuf_byte_window.sv
source/ibuf_top.sv
bench/ibuf_tb.sv
